/* bench/tb_store_queue.sv */
`default_nettype none
`timescale 1ns/1ns

`include "sq_consts.svh"

module tb_store_queue;

    localparam int RANDOM_CYCLES   = 1500;
    localparam int DIRECTED_CYCLES = 300;
    localparam int CYCLE_LIMIT     = 20 * (RANDOM_CYCLES + DIRECTED_CYCLES);
    // few doublewords so stores and loads collide often
    localparam logic [`SQ_ADDR_W-1:0] ADDR_BASE = 29'h0123450;

    logic                  clock;
    logic                  arst_n;
    logic                  alloc_valid;
    sq_pkg::rob_id_t       alloc_rob_id;
    logic                  alloc_ready;
    sq_pkg::sq_id_t        alloc_sq_id;
    sq_pkg::sq_fill_t      fill;
    logic                  commit_valid;
    sq_pkg::rob_id_t       commit_rob_id;
    logic                  flush_valid;
    sq_pkg::sq_id_t        flush_sq_id;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`SQ_ADDR_W-1:0] wb_adr;
    logic [`SQ_DATA_W-1:0] wb_dat_w;
    logic [`SQ_MASK_W-1:0] wb_sel;
    logic                  wb_ack;
    sq_pkg::fwd_req_t      fwd_req;
    sq_pkg::fwd_resp_t     fwd_resp;

    // reference model of the entries, indexed like the DUT slots
    logic [`SQ_DEPTH-1:0]  m_valid;
    logic [`SQ_DEPTH-1:0]  m_filled;
    logic [`SQ_DEPTH-1:0]  m_committed;
    sq_pkg::rob_id_t       m_rob  [`SQ_DEPTH];
    logic [`SQ_ADDR_W-1:0] m_addr [`SQ_DEPTH];
    logic [`SQ_DATA_W-1:0] m_data [`SQ_DEPTH];
    logic [`SQ_MASK_W-1:0] m_mask [`SQ_DEPTH];
    sq_pkg::sq_id_t        m_enq;
    sq_pkg::sq_id_t        m_deq;
    logic                  pop_next;
    sq_pkg::rob_id_t       next_rob;
    logic                  fwd_pending;
    sq_pkg::fwd_resp_t     fwd_exp;
    logic                  ack_enable;
    logic                  bus_busy;
    int                    ack_wait;
    logic [31:0]           seed;
    int                    checks;
    int                    errors;
    int                    writes;
    int                    watchdog = 0;

    store_queue_top u_store_queue_top (
        .clock         (clock),
        .arst_n        (arst_n),
        .alloc_valid   (alloc_valid),
        .alloc_rob_id  (alloc_rob_id),
        .alloc_ready   (alloc_ready),
        .alloc_sq_id   (alloc_sq_id),
        .fill          (fill),
        .commit_valid  (commit_valid),
        .commit_rob_id (commit_rob_id),
        .flush_valid   (flush_valid),
        .flush_sq_id   (flush_sq_id),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_sel        (wb_sel),
        .wb_ack        (wb_ack),
        .fwd_req       (fwd_req),
        .fwd_resp      (fwd_resp)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        watchdog <= watchdog + 1;
        if (watchdog >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles, stopped", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] w;
        w = rand_word();
        return int'(w[30:8]) % n;
    endfunction

    function automatic logic [`SQ_ADDR_W-1:0] pick_dword();
        logic [31:0] w;
        w = rand_word();
        return ADDR_BASE + {{(`SQ_ADDR_W-2){1'b0}}, w[21:20]};
    endfunction

    function automatic logic [`SQ_IDX_W-1:0] slot_from_head(input int n);
        sq_pkg::sq_id_t p;
        p = m_deq + sq_pkg::sq_id_t'(n);
        return p[`SQ_IDX_W-1:0];
    endfunction

    task automatic compare_sq_id(input string what, input sq_pkg::sq_id_t got,
                                 input sq_pkg::sq_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s sq id %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_bus_write(input logic [`SQ_ADDR_W-1:0] adr,
                                     input logic [`SQ_DATA_W-1:0] dat,
                                     input logic [`SQ_MASK_W-1:0] sel,
                                     input logic [`SQ_ADDR_W-1:0] exp_adr,
                                     input logic [`SQ_DATA_W-1:0] exp_dat,
                                     input logic [`SQ_MASK_W-1:0] exp_sel);
        checks++;
        if (adr !== exp_adr || dat !== exp_dat || sel !== exp_sel) begin
            errors++;
            $display("Fail at %0t ns: bus write adr %h dat %h sel %h, expected %h %h %h",
                     $time, adr, dat, sel, exp_adr, exp_dat, exp_sel);
        end
    endtask

    task automatic compare_fwd(input sq_pkg::fwd_resp_t got, input sq_pkg::fwd_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: forward full %b mask %h data %h, expected %b %h %h",
                     $time, got.full, got.byte_mask, got.data,
                     exp.full, exp.byte_mask, exp.data);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // advance the model by the edge that just consumed the driven inputs
    task automatic update_model();
        sq_pkg::sq_id_t       p;
        logic [`SQ_IDX_W-1:0] idx;
        int                   n;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (fill.valid && m_valid[i] && m_rob[i] == fill.rob_id) begin
                m_filled[i] = 1'b1;
                m_addr[i]   = fill.addr;
                m_data[i]   = fill.data;
                m_mask[i]   = fill.byte_mask;
            end
            if (commit_valid && m_valid[i] && m_rob[i] == commit_rob_id) begin
                m_committed[i] = 1'b1;
            end
        end
        idx = m_enq[`SQ_IDX_W-1:0];
        if (alloc_valid && !flush_valid && !m_valid[idx]) begin
            m_valid[idx]     = 1'b1;
            m_filled[idx]    = 1'b0;
            m_committed[idx] = 1'b0;
            m_rob[idx]       = alloc_rob_id;
            m_enq            = m_enq + 1'b1;
        end
        // redirect drops everything from the flush point to the tail
        if (flush_valid) begin
            n = int'(sq_pkg::sq_id_t'(m_enq - flush_sq_id));
            p = flush_sq_id;
            for (int k = 0; k < n; k++) begin
                m_valid[p[`SQ_IDX_W-1:0]] = 1'b0;
                p = p + 1'b1;
            end
            m_enq = flush_sq_id;
        end
        // head is freed one edge after the ack edge
        if (pop_next) begin
            m_valid[m_deq[`SQ_IDX_W-1:0]] = 1'b0;
            m_deq = m_deq + 1'b1;
        end
        pop_next = wb_ack;
    endtask

    // wishbone slave with an ack delay of 0 to 3 cycles
    task automatic respond_bus();
        logic [`SQ_IDX_W-1:0] h;
        h = m_deq[`SQ_IDX_W-1:0];
        wb_ack = 1'b0;
        if (!wb_cyc) begin
            bus_busy = 1'b0;
        end else begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                ack_wait = rand_below(4);
                check_flag("wb_stb", wb_stb, 1'b1);
                check_flag("wb_we", wb_we, 1'b1);
                if (!(m_valid[h] && m_filled[h] && m_committed[h])) begin
                    errors++;
                    $display("Fail at %0t ns: bus write started for a store not committed",
                             $time);
                end
                compare_bus_write(wb_adr, wb_dat_w, wb_sel, m_addr[h], m_data[h], m_mask[h]);
            end
            if (ack_enable) begin
                if (ack_wait == 0) begin
                    wb_ack = 1'b1;
                    writes++;
                end else begin
                    ack_wait--;
                end
            end
        end
    endtask

    task automatic predict_fwd();
        int                    older;
        int                    nb;
        logic [`SQ_IDX_W-1:0]  idx;
        logic [`SQ_MASK_W-1:0] need;
        fwd_exp = '0;
        fwd_exp.valid = 1'b1;
        older = int'(sq_pkg::sq_id_t'(fwd_req.sq_id - m_deq));
        // oldest first so younger bytes win
        for (int k = 0; k < older; k++) begin
            idx = slot_from_head(k);
            if (m_valid[idx] && m_filled[idx]
                && m_addr[idx] == fwd_req.addr[`SQ_BADDR_W-1:3]) begin
                for (int b = 0; b < `SQ_MASK_W; b++) begin
                    if (m_mask[idx][b]) begin
                        fwd_exp.data[8*b +: 8] = m_data[idx][8*b +: 8];
                    end
                end
                fwd_exp.byte_mask = fwd_exp.byte_mask | m_mask[idx];
            end
        end
        nb = 1 << int'(fwd_req.size);
        need = '0;
        for (int b = 0; b < nb; b++) begin
            need[(int'(fwd_req.addr[2:0]) / nb) * nb + b] = 1'b1;
        end
        fwd_exp.full = ((fwd_exp.byte_mask & need) == need);
    endtask

    // one clock cycle: update model, check outputs, drive the next inputs
    task automatic step(input logic do_alloc, input logic do_fill, input logic do_commit,
                        input logic do_flush, input logic do_fwd);
        int                   count;
        int                   first_open;
        int                   pick;
        logic [`SQ_IDX_W-1:0] idx;
        logic [31:0]          w;
        @(posedge clock);
        #1;
        update_model();
        check_flag("alloc_ready", alloc_ready,
                   !m_valid[m_enq[`SQ_IDX_W-1:0]] && !flush_valid);
        check_flag("fwd_resp.valid", fwd_resp.valid, fwd_pending);
        if (fwd_pending) begin
            compare_fwd(fwd_resp, fwd_exp);
        end
        respond_bus();
        count = int'(sq_pkg::sq_id_t'(m_enq - m_deq));
        first_open = 0;
        while (first_open < count && m_committed[slot_from_head(first_open)]) begin
            first_open++;
        end
        alloc_valid  = 1'b0;
        fill         = '0;
        commit_valid = 1'b0;
        flush_valid  = 1'b0;
        fwd_req      = '0;
        // only uncommitted tails are flushed
        if (do_flush && first_open < count) begin
            flush_valid = 1'b1;
            flush_sq_id = m_deq + sq_pkg::sq_id_t'(first_open + rand_below(count - first_open));
        end else begin
            if (do_alloc) begin
                alloc_valid  = 1'b1;
                alloc_rob_id = next_rob;
                compare_sq_id("alloc", alloc_sq_id, m_enq);
                if (!m_valid[m_enq[`SQ_IDX_W-1:0]]) begin
                    next_rob = next_rob + 1'b1;
                end
            end
            if (do_fill) begin
                pick = rand_below(`SQ_DEPTH);
                for (int k = 0; k < `SQ_DEPTH; k++) begin
                    idx = slot_from_head(pick + k);
                    if (!fill.valid && m_valid[idx] && !m_filled[idx]) begin
                        w              = rand_word();
                        fill.valid     = 1'b1;
                        fill.rob_id    = m_rob[idx];
                        fill.addr      = pick_dword();
                        fill.data      = {rand_word(), rand_word()};
                        fill.byte_mask = w[23:16];
                    end
                end
            end
            if (do_commit && first_open < count && m_filled[slot_from_head(first_open)]) begin
                commit_valid  = 1'b1;
                commit_rob_id = m_rob[slot_from_head(first_open)];
            end
        end
        fwd_pending = do_fwd;
        if (do_fwd) begin
            w             = rand_word();
            fwd_req.valid = 1'b1;
            fwd_req.sq_id = m_deq + sq_pkg::sq_id_t'(rand_below(count + 1));
            fwd_req.addr  = {pick_dword(), w[14:12]};
            fwd_req.size  = sq_pkg::load_size_e'(w[17:16]);
            predict_fwd();
        end
    endtask

    task automatic drain_all();
        while (m_deq != m_enq) begin
            step(1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: done, no errors", name);
        end else begin
            $display("%s: done, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int             errors_before;
        sq_pkg::sq_id_t flushed;
        clock         = 1'b0;
        arst_n        = 1'b0;
        alloc_valid   = 1'b0;
        alloc_rob_id  = '0;
        fill          = '0;
        commit_valid  = 1'b0;
        commit_rob_id = '0;
        flush_valid   = 1'b0;
        flush_sq_id   = '0;
        wb_ack        = 1'b0;
        fwd_req       = '0;
        m_valid       = '0;
        m_filled      = '0;
        m_committed   = '0;
        m_enq         = '0;
        m_deq         = '0;
        pop_next      = 1'b0;
        next_rob      = '0;
        fwd_pending   = 1'b0;
        ack_enable    = 1'b1;
        bus_busy      = 1'b0;
        ack_wait      = 0;
        seed          = 32'hcedb;
        checks        = 0;
        errors        = 0;
        writes        = 0;
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;

        errors_before = errors;
        check_flag("alloc_ready after reset", alloc_ready, 1'b1);
        check_flag("wb_cyc after reset", wb_cyc, 1'b0);
        check_flag("fwd_resp.valid after reset", fwd_resp.valid, 1'b0);
        repeat (16) step(1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        drain_all();
        report_test("reset and allocation", errors_before);

        // ack held back until the queue is full
        errors_before = errors;
        ack_enable = 1'b0;
        repeat (`SQ_DEPTH) step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        check_flag("alloc_ready with queue full", alloc_ready, 1'b0);
        repeat (12) step(1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        check_flag("alloc_ready while ack is held", alloc_ready, 1'b0);
        ack_enable = 1'b1;
        while (m_valid[m_enq[`SQ_IDX_W-1:0]]) begin
            step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        check_flag("alloc_ready after pop", alloc_ready, 1'b1);
        drain_all();
        report_test("full queue", errors_before);

        errors_before = errors;
        repeat (4) step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (4) step(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
        step(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        flushed = flush_sq_id;
        step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_sq_id("alloc after flush", alloc_sq_id, flushed);
        drain_all();
        report_test("flush", errors_before);

        errors_before = errors;
        repeat (RANDOM_CYCLES) begin
            step(rand_below(100) < 55, rand_below(100) < 50, rand_below(100) < 45,
                 rand_below(100) < 4, rand_below(100) < 70);
        end
        drain_all();
        report_test("random traffic", errors_before);

        step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        $display("checks %0d, errors %0d, bus writes %0d", checks, errors, writes);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/sq_consts.svh */
`ifndef SQ_CONSTS_SVH
`define SQ_CONSTS_SVH

// number of store queue entries
`define SQ_DEPTH 8

// entry index width, pointers carry one more bit for wrap
`define SQ_IDX_W 3

// reorder buffer id width including its wrap bit
`define ROB_ID_W 7

// store data width
`define SQ_DATA_W 64

// byte lanes per store, one select line each
`define SQ_MASK_W (`SQ_DATA_W / 8)

// doubleword address, byte address without its low three bits
`define SQ_ADDR_W 29

// byte address as seen by loads
`define SQ_BADDR_W (`SQ_ADDR_W + 3)

`endif

/* common/sq_pkg.sv */
`default_nettype none

`include "sq_consts.svh"

package sq_pkg;

    // entry index plus wrap bit
    typedef logic [`SQ_IDX_W:0] sq_id_t;

    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } load_size_e;

    typedef enum logic {
        drain_idle = 1'b0,
        drain_bus  = 1'b1
    } drain_state_e;

    // one entry as reported by the array
    typedef struct packed {
        logic                   valid;
        logic                   filled;
        logic                   committed;
        rob_id_t                rob_id;
        logic [`SQ_ADDR_W-1:0]  addr;
        logic [`SQ_DATA_W-1:0]  data;
        logic [`SQ_MASK_W-1:0]  byte_mask;
    } sq_entry_t;

    // writeback fill from the memory stage
    typedef struct packed {
        logic                   valid;
        rob_id_t                rob_id;
        logic [`SQ_ADDR_W-1:0]  addr;
        logic [`SQ_DATA_W-1:0]  data;
        logic [`SQ_MASK_W-1:0]  byte_mask;
    } sq_fill_t;

    // sq_id is the load's allocation point, i.e. stores older than the load
    typedef struct packed {
        logic                   valid;
        sq_id_t                 sq_id;
        logic [`SQ_BADDR_W-1:0] addr;
        load_size_e             size;
    } fwd_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   full;
        logic [`SQ_DATA_W-1:0]  data;
        logic [`SQ_MASK_W-1:0]  byte_mask;
    } fwd_resp_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/sq_pkg.sv
store_queue/sq_entry_array.sv
store_queue/sq_drain.sv
store_queue/sq_forward.sv
verilog/store_queue_top.sv
bench/tb_store_queue.sv

/* run_sim.sh */
#!/bin/sh
# build the store queue testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_store_queue -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_store_queue)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* store_queue/sq_drain.sv */
`default_nettype none
`timescale 1ns/1ns

`include "sq_consts.svh"

module sq_drain (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire sq_pkg::sq_entry_t     head,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [`SQ_ADDR_W-1:0]      wb_adr,
    output logic [`SQ_DATA_W-1:0]      wb_dat_w,
    output logic [`SQ_MASK_W-1:0]      wb_sel,
    input  wire                        wb_ack,
    output logic                       head_pop
);

    sq_pkg::drain_state_e  state_q;
    logic                  pop_q;
    logic                  head_ready;
    logic [`SQ_ADDR_W-1:0] adr_q;
    logic [`SQ_DATA_W-1:0] dat_q;
    logic [`SQ_MASK_W-1:0] sel_q;

    // head still shows the popped store while the pop is in flight
    assign head_ready = head.valid && head.filled && head.committed && !pop_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= sq_pkg::drain_idle;
            pop_q   <= 1'b0;
        end else begin
            pop_q <= 1'b0;
            case (state_q)
                sq_pkg::drain_idle: begin
                    if (head_ready) begin
                        state_q <= sq_pkg::drain_bus;
                    end
                end
                sq_pkg::drain_bus: begin
                    // single write done, release the head next cycle
                    if (wb_ack) begin
                        state_q <= sq_pkg::drain_idle;
                        pop_q   <= 1'b1;
                    end
                end
                default: begin
                    state_q <= sq_pkg::drain_idle;
                end
            endcase
        end
    end

    // capture the store when the write is launched
    always_ff @(posedge clock) begin
        if (state_q == sq_pkg::drain_idle && head_ready) begin
            adr_q <= head.addr;
            dat_q <= head.data;
            sel_q <= head.byte_mask;
        end
    end

    assign wb_cyc   = (state_q == sq_pkg::drain_bus);
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc;
    assign wb_adr   = adr_q;
    assign wb_dat_w = dat_q;
    assign wb_sel   = sel_q;
    assign head_pop = pop_q;

    // classic cycle, the head entry must not change under a stalled write
    a_bus_hold: assert property (@(posedge clock) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && (wb_adr == head.addr)
                              && (wb_dat_w == head.data)
                              && (wb_sel == head.byte_mask));

endmodule

`default_nettype wire

/* store_queue/sq_entry_array.sv */
`default_nettype none
`timescale 1ns/1ns

`include "sq_consts.svh"

module sq_entry_array (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire                                  alloc_valid,
    input  wire sq_pkg::rob_id_t                 alloc_rob_id,
    output logic                                 alloc_ready,
    output sq_pkg::sq_id_t                       alloc_sq_id,
    input  wire sq_pkg::sq_fill_t                fill,
    input  wire                                  commit_valid,
    input  wire sq_pkg::rob_id_t                 commit_rob_id,
    input  wire                                  flush_valid,
    input  wire sq_pkg::sq_id_t                  flush_sq_id,
    input  wire                                  head_pop,
    output sq_pkg::sq_entry_t [`SQ_DEPTH-1:0]    entries,
    output sq_pkg::sq_id_t                       head_ptr
);

    logic [`SQ_DEPTH-1:0]  valid_q;
    logic [`SQ_DEPTH-1:0]  filled_q;
    logic [`SQ_DEPTH-1:0]  committed_q;
    sq_pkg::rob_id_t       rob_id_q [`SQ_DEPTH];
    logic [`SQ_ADDR_W-1:0] addr_q   [`SQ_DEPTH];
    logic [`SQ_DATA_W-1:0] data_q   [`SQ_DEPTH];
    logic [`SQ_MASK_W-1:0] mask_q   [`SQ_DEPTH];

    sq_pkg::sq_id_t        enq_ptr;
    sq_pkg::sq_id_t        deq_ptr;
    logic [`SQ_IDX_W-1:0]  enq_idx;
    logic [`SQ_IDX_W-1:0]  deq_idx;
    sq_pkg::sq_id_t        flush_cnt;
    sq_pkg::sq_id_t        occupancy;
    logic                  alloc_fire;

    logic [`SQ_DEPTH-1:0]  alloc_dec;
    logic [`SQ_DEPTH-1:0]  fill_dec;
    logic [`SQ_DEPTH-1:0]  commit_dec;
    logic [`SQ_DEPTH-1:0]  flush_dec;
    logic [`SQ_DEPTH-1:0]  pop_dec;

    assign enq_idx = enq_ptr[`SQ_IDX_W-1:0];
    assign deq_idx = deq_ptr[`SQ_IDX_W-1:0];

    // slot at the tail must be free, and a redirect owns the tail this cycle
    assign alloc_ready = ~valid_q[enq_idx] & ~flush_valid;
    assign alloc_fire  = alloc_valid & alloc_ready;
    assign alloc_sq_id = enq_ptr;
    assign head_ptr    = deq_ptr;

    // number of entries from the flush point up to the tail
    assign flush_cnt = enq_ptr - flush_sq_id;
    assign occupancy = enq_ptr - deq_ptr;

    always_comb begin
        logic [`SQ_IDX_W-1:0] offset;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            offset        = i[`SQ_IDX_W-1:0] - flush_sq_id[`SQ_IDX_W-1:0];
            alloc_dec[i]  = alloc_fire && (int'(enq_idx) == i);
            pop_dec[i]    = head_pop && (int'(deq_idx) == i);
            flush_dec[i]  = flush_valid && ({1'b0, offset} < flush_cnt);
            fill_dec[i]   = fill.valid && valid_q[i] && (rob_id_q[i] == fill.rob_id);
            commit_dec[i] = commit_valid && valid_q[i] && (rob_id_q[i] == commit_rob_id);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q     <= '0;
            filled_q    <= '0;
            committed_q <= '0;
            enq_ptr     <= '0;
            deq_ptr     <= '0;
        end else begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                if (flush_dec[i] || pop_dec[i]) begin
                    valid_q[i]     <= 1'b0;
                    filled_q[i]    <= 1'b0;
                    committed_q[i] <= 1'b0;
                end else if (alloc_dec[i]) begin
                    valid_q[i]     <= 1'b1;
                    filled_q[i]    <= 1'b0;
                    committed_q[i] <= 1'b0;
                end else begin
                    if (fill_dec[i]) begin
                        filled_q[i] <= 1'b1;
                    end
                    if (commit_dec[i]) begin
                        committed_q[i] <= 1'b1;
                    end
                end
            end
            // tail rolls back on redirect
            if (flush_valid) begin
                enq_ptr <= flush_sq_id;
            end else if (alloc_fire) begin
                enq_ptr <= enq_ptr + 1'b1;
            end
            if (head_pop) begin
                deq_ptr <= deq_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (alloc_dec[i]) begin
                rob_id_q[i] <= alloc_rob_id;
            end
            if (fill_dec[i]) begin
                addr_q[i] <= fill.addr;
                data_q[i] <= fill.data;
                mask_q[i] <= fill.byte_mask;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            entries[i].valid     = valid_q[i];
            entries[i].filled    = filled_q[i];
            entries[i].committed = committed_q[i];
            entries[i].rob_id    = rob_id_q[i];
            entries[i].addr      = addr_q[i];
            entries[i].data      = data_q[i];
            entries[i].byte_mask = mask_q[i];
        end
    end

    // drain side may only release a store that has retired
    a_pop_committed: assert property (@(posedge clock) disable iff (!arst_n)
        head_pop |-> valid_q[deq_idx] && committed_q[deq_idx]);

    a_ptr_span: assert property (@(posedge clock) disable iff (!arst_n)
        occupancy <= `SQ_DEPTH);

endmodule

`default_nettype wire

/* store_queue/sq_forward.sv */
`default_nettype none
`timescale 1ns/1ns

`include "sq_consts.svh"

module sq_forward (
    input  wire                                clock,
    input  wire                                arst_n,
    input  wire sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries,
    input  wire sq_pkg::sq_id_t                head_ptr,
    input  wire sq_pkg::fwd_req_t              req,
    output sq_pkg::fwd_resp_t                  resp
);

    logic                  same_flag;
    logic [`SQ_IDX_W-1:0]  head_idx;
    logic [`SQ_IDX_W-1:0]  req_idx;
    logic [`SQ_ADDR_W-1:0] req_dw;
    logic [2:0]            offset;
    logic [`SQ_DEPTH-1:0]  older;
    logic [`SQ_DEPTH-1:0]  hit;
    logic [`SQ_DATA_W-1:0] merge_data;
    logic [`SQ_MASK_W-1:0] merge_mask;
    logic [`SQ_MASK_W-1:0] need_mask;

    logic                  resp_valid_q;
    logic                  resp_full_q;
    logic [`SQ_DATA_W-1:0] resp_data_q;
    logic [`SQ_MASK_W-1:0] resp_mask_q;

    assign head_idx  = head_ptr[`SQ_IDX_W-1:0];
    assign req_idx   = req.sq_id[`SQ_IDX_W-1:0];
    assign same_flag = (head_ptr[`SQ_IDX_W] == req.sq_id[`SQ_IDX_W]);
    assign req_dw    = req.addr[`SQ_BADDR_W-1:3];
    assign offset    = req.addr[2:0];

    // same flag gives one range [head, sq_id), otherwise the range wraps
    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (same_flag) begin
                older[i] = (i >= int'(head_idx)) && (i < int'(req_idx));
            end else begin
                older[i] = (i >= int'(head_idx)) || (i < int'(req_idx));
            end
            hit[i] = older[i] && entries[i].valid && entries[i].filled
                     && (entries[i].addr == req_dw);
        end
    end

    // walk from the head so younger stores overwrite older bytes
    always_comb begin
        logic [`SQ_IDX_W-1:0] idx;
        merge_data = '0;
        merge_mask = '0;
        for (int k = 0; k < `SQ_DEPTH; k++) begin
            idx = head_idx + k[`SQ_IDX_W-1:0];
            if (hit[idx]) begin
                for (int b = 0; b < `SQ_MASK_W; b++) begin
                    if (entries[idx].byte_mask[b]) begin
                        merge_data[8*b +: 8] = entries[idx].data[8*b +: 8];
                    end
                end
                merge_mask = merge_mask | entries[idx].byte_mask;
            end
        end
    end

    // bytes the load needs, aligned to its size
    always_comb begin
        case (req.size)
            sq_pkg::size_byte: need_mask = 8'h01 << offset;
            sq_pkg::size_half: need_mask = 8'h03 << {offset[2:1], 1'b0};
            sq_pkg::size_word: need_mask = 8'h0f << {offset[2], 2'b00};
            default:           need_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= req.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (req.valid) begin
            resp_data_q <= merge_data;
            resp_mask_q <= merge_mask;
            resp_full_q <= ((merge_mask & need_mask) == need_mask);
        end
    end

    assign resp = '{valid:     resp_valid_q,
                    full:      resp_full_q,
                    data:      resp_data_q,
                    byte_mask: resp_mask_q};

endmodule

`default_nettype wire

/* verilog/store_queue_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "sq_consts.svh"

module store_queue_top (
    input  wire                        clock,
    input  wire                        arst_n,
    // dispatch
    input  wire                        alloc_valid,
    input  wire sq_pkg::rob_id_t       alloc_rob_id,
    output wire                        alloc_ready,
    output wire sq_pkg::sq_id_t        alloc_sq_id,
    // memory stage writeback
    input  wire sq_pkg::sq_fill_t      fill,
    // retirement
    input  wire                        commit_valid,
    input  wire sq_pkg::rob_id_t       commit_rob_id,
    // redirect
    input  wire                        flush_valid,
    input  wire sq_pkg::sq_id_t        flush_sq_id,
    // wishbone write master
    output wire                        wb_cyc,
    output wire                        wb_stb,
    output wire                        wb_we,
    output wire [`SQ_ADDR_W-1:0]       wb_adr,
    output wire [`SQ_DATA_W-1:0]       wb_dat_w,
    output wire [`SQ_MASK_W-1:0]       wb_sel,
    input  wire                        wb_ack,
    // load forwarding
    input  wire sq_pkg::fwd_req_t      fwd_req,
    output wire sq_pkg::fwd_resp_t     fwd_resp
);

    sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries;
    sq_pkg::sq_entry_t                 head_entry;
    sq_pkg::sq_id_t                    head_ptr;
    logic                              head_pop;

    // oldest store goes to the drain master
    assign head_entry = entries[head_ptr[`SQ_IDX_W-1:0]];

    sq_entry_array u_sq_entry_array (
        .clock         (clock),
        .arst_n        (arst_n),
        .alloc_valid   (alloc_valid),
        .alloc_rob_id  (alloc_rob_id),
        .alloc_ready   (alloc_ready),
        .alloc_sq_id   (alloc_sq_id),
        .fill          (fill),
        .commit_valid  (commit_valid),
        .commit_rob_id (commit_rob_id),
        .flush_valid   (flush_valid),
        .flush_sq_id   (flush_sq_id),
        .head_pop      (head_pop),
        .entries       (entries),
        .head_ptr      (head_ptr)
    );

    sq_drain u_sq_drain (
        .clock    (clock),
        .arst_n   (arst_n),
        .head     (head_entry),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .head_pop (head_pop)
    );

    sq_forward u_sq_forward (
        .clock    (clock),
        .arst_n   (arst_n),
        .entries  (entries),
        .head_ptr (head_ptr),
        .req      (fwd_req),
        .resp     (fwd_resp)
    );

endmodule

`default_nettype wire
